// ==== common/tx_stats_pkg.sv ====
// widths and header words are fixed here; record and beat layouts assume a 256-bit stream
package tx_stats_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // stream and field widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_W = 256;
  localparam int STRB_W = DATA_W / 8;
  localparam int USER_W = 128;
  localparam int TS_W   = 64;
  localparam int SEQ_W  = 32;

  // interface number stamped into every record
  localparam int IF_NO = 20;

  ////////////////////////////////////////////////////////////////////////////
  // generator constants
  ////////////////////////////////////////////////////////////////////////////

  // eth dst/src, ethertype 0x8808, ip header up to the first half of the dst address
  // byte 0 of the frame sits in tdata[7:0]
  localparam logic [DATA_W-1:0] TX_HDR_DATA = {8'h00, 32'h0000_0700, 16'h0900,
    32'h0000_0600, 8'h01, 32'h0000_0000, 16'h0200, 16'h0888,
    48'hbbbb_bbbb_bbbb, 48'haaaa_aaaa_aaaa};

  // length 64, source port 1
  localparam logic [USER_W-1:0] TX_HDR_USER = {96'h0, 8'h05, 8'h01, 16'h0040};

  localparam logic [7:0]  PAD_BYTE = 8'hc3;
  // rest of the ip dst address, opens the second beat
  localparam logic [15:0] IP_TAIL  = 16'h0007;

  // second beat layout: ip tail, sequence number, tx stamp, then filler
  localparam int SEQ_LSB = 16;
  localparam int TS_LSB  = 48;

  ////////////////////////////////////////////////////////////////////////////
  // statistics fifo and dma drain
  ////////////////////////////////////////////////////////////////////////////

  // same eth/ip skeleton with the dma-side mac addresses
  localparam logic [DATA_W-1:0] DMA_HDR_DATA = {8'h00, 32'h0000_0700, 16'h0900,
    32'h0000_0600, 8'h01, 32'h0000_0000, 16'h0200, 16'h0008,
    48'hcccc_cccc_cccc, 48'hdddd_dddd_dddd};

  // 800 byte packet to the cpu port
  localparam logic [USER_W-1:0] DMA_HDR_USER = {96'h0, 8'h02, 8'h80, 16'h0320};

  localparam int FIFO_DEPTH       = 30;
  localparam int FIFO_DRAIN_LEVEL = 25;
  localparam int DRAIN_BEATS      = 29;

  // counters sized to hold their top value
  localparam int CNT_W   = $clog2(FIFO_DEPTH + 1);
  localparam int PTR_W   = $clog2(FIFO_DEPTH);
  localparam int DRAIN_W = $clog2(DRAIN_BEATS + 1);

  // record tags
  localparam logic [31:0] REC_MARK = 32'hcafe_cafe;
  localparam logic [15:0] REC_TAG  = 16'hcafe;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  // one stream beat, valid and ready travel beside it
  typedef struct packed {
    logic [DATA_W-1:0] tdata;
    logic [STRB_W-1:0] tstrb;
    logic [USER_W-1:0] tuser;
    logic              tlast;
  } axis_beat_t;

  // generator settings
  typedef struct packed {
    logic [SEQ_W-1:0] gap;
    logic [SEQ_W-1:0] frames;
    logic [SEQ_W-1:0] words;
    logic [SEQ_W-1:0] last_strb;
  } gen_cfg_t;

  // statistics record, msb first
  typedef struct packed {
    logic [15:0]      if_no;
    logic [31:0]      mark;
    logic [TS_W-1:0]  ts_tx;
    logic [TS_W-1:0]  ts_rx;
    logic [SEQ_W-1:0] seq_arr;
    logic [SEQ_W-1:0] seq_exp;
    logic [15:0]      tag;
  } stat_rec_t;

endpackage

// ==== tx_gen/tx_frame_gen.sv ====
// gate is a pulse, a held gate repeats the burst; gap below 2 runs as 2, zero payload as 1 beat
`timescale 1ns/1ns

module tx_frame_gen
  import tx_stats_pkg::*;
(
  input  logic            S_AXI_ACLK,
  input  logic            S_AXI_ARESETN,
  input  logic            clr,
  input  logic            gate,
  input  gen_cfg_t        gen_cfg,
  input  logic [TS_W-1:0] stamp_counter,
  output axis_beat_t      beat,
  output logic            tvalid,
  input  logic            tready
);

  typedef enum logic [1:0] {ST_GATE, ST_GAP, ST_HEAD, ST_REM} gen_state_t;

  gen_state_t        state;
  logic              gate_q;
  gen_cfg_t          cfg_q;
  logic [SEQ_W-1:0]  gap_cnt;
  logic [SEQ_W-1:0]  gap_len;
  logic [SEQ_W-1:0]  frames_left;
  logic [SEQ_W-1:0]  beats_left;
  logic [SEQ_W-1:0]  words_len;
  logic [SEQ_W-1:0]  seq;
  logic              second;
  logic              out_free;
  logic              last_beat;
  logic [STRB_W-1:0] last_strb;

  // output register can take a new beat
  assign out_free  = !tvalid || tready;

  assign gap_len   = (cfg_q.gap < SEQ_W'(2)) ? SEQ_W'(2) : cfg_q.gap;
  assign words_len = (cfg_q.words == '0) ? SEQ_W'(1) : cfg_q.words;
  assign last_beat = (beats_left == SEQ_W'(1));
  // zero strobe setting means a full last beat
  assign last_strb = (cfg_q.last_strb == '0) ? '1 : cfg_q.last_strb[STRB_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      state       <= ST_GATE;
      gate_q      <= 1'b0;
      gap_cnt     <= '0;
      frames_left <= '0;
      beats_left  <= '0;
      seq         <= '0;
      second      <= 1'b0;
      tvalid      <= 1'b0;
    end else if (clr) begin
      state       <= ST_GATE;
      gate_q      <= 1'b0;
      gap_cnt     <= '0;
      frames_left <= '0;
      beats_left  <= '0;
      seq         <= '0;
      second      <= 1'b0;
      tvalid      <= 1'b0;
    end else begin
      gate_q <= gate;
      // beat taken, drop valid unless a new one loads below
      if (out_free) begin
        tvalid <= 1'b0;
      end
      case (state)
        ST_GATE: begin
          // a zero frame count leaves the generator idle
          if (gate_q && gen_cfg.frames != '0) begin
            frames_left <= gen_cfg.frames;
            gap_cnt     <= '0;
            state       <= ST_GAP;
          end
        end
        ST_GAP: begin
          if (gap_cnt >= gap_len - 1'b1) begin
            state <= ST_HEAD;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        ST_HEAD: begin
          if (out_free) begin
            tvalid     <= 1'b1;
            beats_left <= words_len;
            second     <= 1'b1;
            state      <= ST_REM;
          end
        end
        ST_REM: begin
          if (out_free) begin
            tvalid <= 1'b1;
            second <= 1'b0;
            if (last_beat) begin
              // frame complete, sequence number survives bursts
              seq         <= seq + 1'b1;
              frames_left <= frames_left - 1'b1;
              gap_cnt     <= '0;
              state       <= (frames_left == SEQ_W'(1)) ? ST_GATE : ST_GAP;
            end else begin
              beats_left <= beats_left - 1'b1;
            end
          end
        end
        default: state <= ST_GATE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // settings and output beat
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (state == ST_GATE && gate_q) begin
      cfg_q <= gen_cfg;
    end
    if (out_free && state == ST_HEAD) begin
      beat.tdata <= TX_HDR_DATA;
      beat.tuser <= TX_HDR_USER;
      beat.tstrb <= '1;
      beat.tlast <= 1'b0;
    end else if (out_free && state == ST_REM) begin
      // stamp is frozen here, so it holds under back-pressure
      beat.tdata <= second ? {{(STRB_W - 14){PAD_BYTE}}, stamp_counter, seq, IP_TAIL}
                           : {STRB_W{PAD_BYTE}};
      beat.tuser <= '0;
      beat.tstrb <= last_beat ? last_strb : '1;
      beat.tlast <= last_beat;
    end
  end

endmodule

// ==== rx_probe/rx_seq_probe.sv ====
// assumes the stream is never stalled and every frame carries its stamp in the second beat
`timescale 1ns/1ns

module rx_seq_probe
  import tx_stats_pkg::*;
(
  input  logic            S_AXI_ACLK,
  input  logic            S_AXI_ARESETN,
  input  logic            clr,
  input  axis_beat_t      s_axis,
  input  logic            s_axis_tvalid,
  input  logic [TS_W-1:0] stamp_counter,
  output logic            rec_wr,
  output stat_rec_t       rec
);

  // wait: next beat is a header, head: next beat is the second, second: rest of frame
  typedef enum logic [1:0] {RX_WAIT, RX_HEAD, RX_SECOND} rx_state_t;

  rx_state_t        state;
  logic [SEQ_W-1:0] rx_count;
  logic             take;

  // second beat of a frame arriving now
  assign take = s_axis_tvalid && (state == RX_HEAD);

  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      state    <= RX_WAIT;
      rx_count <= '0;
      rec_wr   <= 1'b0;
    end else if (clr) begin
      state    <= RX_WAIT;
      rx_count <= '0;
      rec_wr   <= 1'b0;
    end else begin
      rec_wr <= take;
      if (take) begin
        rx_count <= rx_count + 1'b1;
      end
      case (state)
        // a single-beat frame carries no stamp and is skipped
        RX_WAIT:   if (s_axis_tvalid && !s_axis.tlast) state <= RX_HEAD;
        RX_HEAD:   if (s_axis_tvalid) state <= s_axis.tlast ? RX_WAIT : RX_SECOND;
        RX_SECOND: if (s_axis_tvalid && s_axis.tlast) state <= RX_WAIT;
        default:   state <= RX_WAIT;
      endcase
    end
  end

  // record built straight from the second beat
  // expected number is the local frame count before the increment
  always_ff @(posedge S_AXI_ACLK) begin
    if (take) begin
      rec.if_no   <= 16'(IF_NO);
      rec.mark    <= REC_MARK;
      rec.ts_tx   <= s_axis.tdata[TS_LSB +: TS_W];
      rec.ts_rx   <= stamp_counter;
      rec.seq_arr <= s_axis.tdata[SEQ_LSB +: SEQ_W];
      rec.seq_exp <= rx_count;
      rec.tag     <= REC_TAG;
    end
  end

endmodule

// ==== stats/stat_fifo.sv ====
// single clock, show-ahead read; writes into a full fifo and pops of an empty one are ignored
`timescale 1ns/1ns

module stat_fifo
  import tx_stats_pkg::*;
(
  input  logic             S_AXI_ACLK,
  input  logic             S_AXI_ARESETN,
  input  logic             clr,
  input  logic             rec_wr,
  input  stat_rec_t        rec,
  input  logic             rec_rd,
  output stat_rec_t        rec_head,
  output logic [CNT_W-1:0] fill_count
);

  stat_rec_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_wr;
  logic             do_rd;

  // depth is not a power of two, pointers wrap by compare
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_wr    = rec_wr && (fill_count != CNT_W'(FIFO_DEPTH));
  assign do_rd    = rec_rd && (fill_count != '0);
  assign rec_head = mem[rd_ptr];

  always_ff @(posedge S_AXI_ACLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= rec;
    end
  end

  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_count <= '0;
    end else if (clr) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_count <= '0;
    end else begin
      if (do_wr) wr_ptr <= next_ptr(wr_ptr);
      if (do_rd) rd_ptr <= next_ptr(rd_ptr);
      // simultaneous push and pop keep the count
      case ({do_wr, do_rd})
        2'b10:   fill_count <= fill_count + 1'b1;
        2'b01:   fill_count <= fill_count - 1'b1;
        default: fill_count <= fill_count;
      endcase
    end
  end

endmodule

// ==== stats/stat_dma_drain.sv ====
// one packet per crossing of the drain level; stops early once the fifo holds a single record
`timescale 1ns/1ns

module stat_dma_drain
  import tx_stats_pkg::*;
(
  input  logic             S_AXI_ACLK,
  input  logic             S_AXI_ARESETN,
  input  logic             clr,
  input  logic [CNT_W-1:0] fill_count,
  input  stat_rec_t        rec_head,
  output logic             rec_rd,
  output axis_beat_t       beat,
  output logic             tvalid,
  input  logic             tready
);

  typedef enum logic [1:0] {DR_WAIT, DR_HEAD, DR_REC} drain_state_t;

  drain_state_t       state;
  logic [DRAIN_W-1:0] rec_cnt;
  logic               first;
  logic               out_free;
  logic               last_rec;

  assign out_free = !tvalid || tready;

  // packet full, or the record being taken empties the fifo
  assign last_rec = (rec_cnt == DRAIN_W'(DRAIN_BEATS - 1)) || (fill_count == CNT_W'(1));

  // pop as the record moves into the output register
  assign rec_rd = (state == DR_REC) && out_free;

  ////////////////////////////////////////////////////////////////////////////
  // packet FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      state   <= DR_WAIT;
      rec_cnt <= '0;
      first   <= 1'b0;
      tvalid  <= 1'b0;
    end else if (clr) begin
      state   <= DR_WAIT;
      rec_cnt <= '0;
      first   <= 1'b0;
      tvalid  <= 1'b0;
    end else begin
      if (out_free) begin
        tvalid <= 1'b0;
      end
      case (state)
        DR_WAIT: begin
          if (fill_count >= CNT_W'(FIFO_DRAIN_LEVEL)) begin
            state <= DR_HEAD;
          end
        end
        DR_HEAD: begin
          // waits here until the last beat of the previous packet has gone
          if (out_free) begin
            tvalid  <= 1'b1;
            rec_cnt <= '0;
            first   <= 1'b1;
            state   <= DR_REC;
          end
        end
        DR_REC: begin
          if (out_free) begin
            tvalid <= 1'b1;
            first  <= 1'b0;
            if (last_rec) begin
              state <= DR_WAIT;
            end else begin
              rec_cnt <= rec_cnt + 1'b1;
            end
          end
        end
        default: state <= DR_WAIT;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output beat
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (out_free && state == DR_HEAD) begin
      beat.tdata <= DMA_HDR_DATA;
      beat.tuser <= DMA_HDR_USER;
      beat.tstrb <= '1;
      beat.tlast <= 1'b0;
    end else if (out_free && state == DR_REC) begin
      // first record beat finishes the ip dst address of the header
      beat.tdata <= first ? {rec_head[DATA_W-1:16], IP_TAIL} : rec_head;
      beat.tuser <= '0;
      beat.tstrb <= '1;
      beat.tlast <= last_rec;
    end
  end

endmodule

// ==== verilog/tx_stats_top.sv ====
// receive side is always ready; rst_count takes effect one cycle late and clears all counters
`timescale 1ns/1ns

module tx_stats_top
  import tx_stats_pkg::*;
(
  input  logic            S_AXI_ACLK,
  input  logic            S_AXI_ARESETN,
  input  gen_cfg_t        gen_cfg,
  input  logic            gate,
  input  logic            rst_count,
  input  logic [TS_W-1:0] stamp_counter,
  // receive stream
  input  axis_beat_t      s_axis,
  input  logic            s_axis_tvalid,
  output logic            s_axis_tready,
  // generated traffic
  output axis_beat_t      m_axis,
  output logic            m_axis_tvalid,
  input  logic            m_axis_tready,
  // statistics packets
  output axis_beat_t      m_axis_dma,
  output logic            m_axis_dma_tvalid,
  input  logic            m_axis_dma_tready
);

  logic             clr;
  logic             rec_wr;
  stat_rec_t        rec;
  stat_rec_t        rec_head;
  logic [CNT_W-1:0] fill_count;
  logic             rec_rd;

  // local counter reset, held during and just after the async reset
  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      clr <= 1'b1;
    end else begin
      clr <= rst_count;
    end
  end

  // probe never stalls the stream
  assign s_axis_tready = 1'b1;

  tx_frame_gen u_tx_frame_gen (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .clr           (clr),
    .gate          (gate),
    .gen_cfg       (gen_cfg),
    .stamp_counter (stamp_counter),
    .beat          (m_axis),
    .tvalid        (m_axis_tvalid),
    .tready        (m_axis_tready)
  );

  rx_seq_probe u_rx_seq_probe (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .clr           (clr),
    .s_axis        (s_axis),
    .s_axis_tvalid (s_axis_tvalid),
    .stamp_counter (stamp_counter),
    .rec_wr        (rec_wr),
    .rec           (rec)
  );

  stat_fifo u_stat_fifo (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .clr           (clr),
    .rec_wr        (rec_wr),
    .rec           (rec),
    .rec_rd        (rec_rd),
    .rec_head      (rec_head),
    .fill_count    (fill_count)
  );

  stat_dma_drain u_stat_dma_drain (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .clr           (clr),
    .fill_count    (fill_count),
    .rec_head      (rec_head),
    .rec_rd        (rec_rd),
    .beat          (m_axis_dma),
    .tvalid        (m_axis_dma_tvalid),
    .tready        (m_axis_dma_tready)
  );

endmodule

// ==== tb/tb_tx_stats_checks.sv ====
// samples both master streams at the rising edge; rst_count may only be pulsed while both are idle
`timescale 1ns/1ns

module tb_tx_stats_checks
  import tx_stats_pkg::*;
(
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  input  logic       rst_count,
  input  gen_cfg_t   gen_cfg,
  input  logic       s_axis_tready,
  input  axis_beat_t m_axis,
  input  logic       m_axis_tvalid,
  input  logic       m_axis_tready,
  input  axis_beat_t m_axis_dma,
  input  logic       m_axis_dma_tvalid,
  input  logic       m_axis_dma_tready,
  output int         err_count,
  output int         frame_count,
  output int         pkt_count
);

  // sent frames waiting for their record, {sequence number, tx stamp}
  logic [SEQ_W+TS_W-1:0] sent_q [$];
  logic [SEQ_W-1:0]      exp_seq = '0;
  int                    beat_idx = 0;
  int                    rec_idx = 0;
  int                    check_errors = 0;
  int                    prop_errors = 0;
  logic                  rst_q = 1'b0;
  logic                  rst_seen = 1'b0;
  logic                  gen_stall = 1'b0;
  logic                  dma_stall = 1'b0;
  axis_beat_t            gen_prev;
  axis_beat_t            dma_prev;

  assign err_count = check_errors + prop_errors;

  initial begin
    frame_count = 0;
    pkt_count   = 0;
  end

  task automatic expect_eq(input string name, input logic [$bits(axis_beat_t)-1:0] got,
                           input logic [$bits(axis_beat_t)-1:0] want);
    assert (got === want) else begin
      $display("Error at %0t: %s expected %0h got %0h", $time, name, want, got);
      check_errors++;
    end
  endtask

  // while ready was low the beat must stay put
  task automatic check_hold(input string name, input logic valid, input axis_beat_t was,
                            input axis_beat_t now);
    expect_eq({name, "_tvalid"}, valid, 1'b1);
    expect_eq({name, " beat"}, now, was);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // generated frames
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_gen_beat();
    logic              last;
    logic [STRB_W-1:0] strb_exp;
    // a zero strobe setting stands for a full last beat
    strb_exp = (gen_cfg.last_strb == '0) ? '1 : gen_cfg.last_strb[STRB_W-1:0];
    last = (beat_idx == int'(gen_cfg.words));
    if (beat_idx == 0) begin
      expect_eq("m_axis.tdata header", m_axis.tdata, TX_HDR_DATA);
      expect_eq("m_axis.tuser header", m_axis.tuser, TX_HDR_USER);
    end else if (beat_idx == 1) begin
      expect_eq("m_axis ip tail", m_axis.tdata[15:0], IP_TAIL);
      expect_eq("m_axis sequence", m_axis.tdata[SEQ_LSB +: SEQ_W], exp_seq);
      expect_eq("m_axis filler", m_axis.tdata[DATA_W-1:TS_LSB+TS_W],
                {((DATA_W - TS_LSB - TS_W) / 8){PAD_BYTE}});
      sent_q.push_back({m_axis.tdata[SEQ_LSB +: SEQ_W], m_axis.tdata[TS_LSB +: TS_W]});
    end else begin
      expect_eq("m_axis filler", m_axis.tdata, {STRB_W{PAD_BYTE}});
    end
    expect_eq("m_axis.tlast", m_axis.tlast, last);
    expect_eq("m_axis.tstrb", m_axis.tstrb, last ? strb_exp : {STRB_W{1'b1}});
    if (m_axis.tlast) begin
      beat_idx = 0;
      exp_seq++;
      frame_count++;
    end else begin
      beat_idx++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // dma packets
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_dma_beat();
    stat_rec_t             r;
    logic [SEQ_W+TS_W-1:0] want;
    r = m_axis_dma.tdata;
    if (rec_idx == 0) begin
      expect_eq("m_axis_dma.tdata header", m_axis_dma.tdata, DMA_HDR_DATA);
      expect_eq("m_axis_dma.tuser header", m_axis_dma.tuser, DMA_HDR_USER);
      expect_eq("m_axis_dma.tlast header", m_axis_dma.tlast, 1'b0);
      // drain may only start once the fifo reached its level
      assert (sent_q.size() >= FIFO_DRAIN_LEVEL) else begin
        $display("Error at %0t: records pending expected >= %0d got %0d", $time,
                 FIFO_DRAIN_LEVEL, sent_q.size());
        check_errors++;
      end
      pkt_count++;
    end else begin
      expect_eq("record if_no", r.if_no, IF_NO);
      expect_eq("record mark", r.mark, REC_MARK);
      // first record beat closes the ip header
      expect_eq(rec_idx == 1 ? "record ip tail" : "record tag", r.tag,
                rec_idx == 1 ? IP_TAIL : REC_TAG);
      expect_eq("record seq_exp", r.seq_exp, r.seq_arr);
      assert (rec_idx <= DRAIN_BEATS) else begin
        $display("Error at %0t: packet records expected <= %0d got %0d", $time,
                 DRAIN_BEATS, rec_idx);
        check_errors++;
      end
      assert (r.ts_rx >= r.ts_tx) else begin
        $display("Error at %0t: record ts_rx expected >= %0h got %0h", $time,
                 r.ts_tx, r.ts_rx);
        check_errors++;
      end
      assert (sent_q.size() > 0) else begin
        $display("Error at %0t: a DMA record arrived with no sent frame left to match it",
                 $time);
        check_errors++;
      end
      if (sent_q.size() > 0) begin
        want = sent_q.pop_front();
        expect_eq("record seq_arr", r.seq_arr, want[TS_W +: SEQ_W]);
        expect_eq("record ts_tx", r.ts_tx, want[TS_W-1:0]);
      end
    end
    if (m_axis_dma.tlast) begin
      rec_idx = 0;
    end else begin
      rec_idx++;
    end
  endtask

  always @(posedge S_AXI_ACLK) begin
    rst_q    <= S_AXI_ARESETN;
    rst_seen <= rst_seen || !S_AXI_ARESETN;
    if (S_AXI_ARESETN && rst_count) begin
      // counter reset clears the fifo and restarts numbering
      sent_q.delete();
      exp_seq  = '0;
      beat_idx = 0;
      rec_idx  = 0;
    end else if (S_AXI_ARESETN) begin
      // probe side never stalls
      expect_eq("s_axis_tready", s_axis_tready, 1'b1);
      if (m_axis_tvalid && m_axis_tready) begin
        check_gen_beat();
      end
      if (m_axis_dma_tvalid && m_axis_dma_tready) begin
        check_dma_beat();
      end
      if (gen_stall) begin
        check_hold("m_axis", m_axis_tvalid, gen_prev, m_axis);
      end
      if (dma_stall) begin
        check_hold("m_axis_dma", m_axis_dma_tvalid, dma_prev, m_axis_dma);
      end
    end
    gen_stall = S_AXI_ARESETN && m_axis_tvalid && !m_axis_tready;
    dma_stall = S_AXI_ARESETN && m_axis_dma_tvalid && !m_axis_dma_tready;
    gen_prev  = m_axis;
    dma_prev  = m_axis_dma;
  end

  // both valids low in reset and on the first cycle after it
  assert property (@(posedge S_AXI_ACLK)
      (rst_seen && (!S_AXI_ARESETN || !rst_q)) |-> (!m_axis_tvalid && !m_axis_dma_tvalid))
    else begin
      $display("Error at %0t: m_axis_tvalid expected 0 got %b, m_axis_dma_tvalid expected 0 got %b",
               $time, $sampled(m_axis_tvalid), $sampled(m_axis_dma_tvalid));
      prop_errors++;
    end

endmodule

// ==== tb/tb_tx_stats.sv ====
// m_axis loops back into s_axis; stalls and gaps come from a fixed-seed LFSR
`timescale 1ns/1ns

module tb_tx_stats
  import tx_stats_pkg::*;
();

  localparam logic [31:0] SEED       = 32'hdfd4;
  localparam int          WAIT_LIMIT = 20000;

  logic            S_AXI_ACLK = 1'b0;
  logic            S_AXI_ARESETN;
  gen_cfg_t        gen_cfg;
  logic            gate;
  logic            rst_count;
  logic [TS_W-1:0] stamp_counter;
  axis_beat_t      s_axis;
  logic            s_axis_tvalid;
  logic            s_axis_tready;
  axis_beat_t      m_axis;
  logic            m_axis_tvalid;
  logic            m_axis_tready;
  axis_beat_t      m_axis_dma;
  logic            m_axis_dma_tvalid;
  logic            m_axis_dma_tready;
  logic [31:0]     rdy_lfsr;
  logic [31:0]     gap_lfsr;
  int              err_count;
  int              frame_count;
  int              pkt_count;
  int              tb_errors = 0;
  int              tests = 0;
  int              failed = 0;
  int              mark = 0;
  logic            timed_out = 1'b0;

  always #5 S_AXI_ACLK = ~S_AXI_ACLK;

  // loopback, a beat counts only when the generator hands it over
  assign s_axis        = m_axis;
  assign s_axis_tvalid = m_axis_tvalid && m_axis_tready;

  tx_stats_top u_tx_stats_top (.*);

  tb_tx_stats_checks u_checks (.*);

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(inout logic [31:0] s, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      s = lfsr_next(s);
      v = {v[30:0], s[0]};
    end
  endtask

  // time base and ready stalls, about one cycle in four
  always @(posedge S_AXI_ACLK) begin
    logic [31:0] bits;
    #1;
    stamp_counter <= stamp_counter + 1'b1;
    take_bits(rdy_lfsr, 2, bits);
    m_axis_tready <= (bits[1:0] != 2'b00);
    take_bits(rdy_lfsr, 2, bits);
    m_axis_dma_tready <= (bits[1:0] != 2'b00);
  end

  // later waits return at once after this
  task automatic note_timeout(input string why);
    $display("%s after %0d frames", why, frame_count);
    timed_out = 1'b1;
  endtask

  task automatic finish_test(input string name);
    int now;
    now = err_count + tb_errors;
    tests++;
    if (now != mark) begin
      failed++;
      $display("test %s: failed with %0d errors", name, now - mark);
    end else begin
      $display("test %s: ok", name);
    end
    mark = now;
  endtask

  task automatic wait_frames(input int target);
    int n;
    n = 0;
    while (!timed_out && frame_count < target && n < WAIT_LIMIT) begin
      @(posedge S_AXI_ACLK);
      #1;
      n++;
    end
    if (!timed_out && frame_count < target) begin
      note_timeout($sformatf("timed out waiting for frame %0d", target));
    end
  endtask

  task automatic wait_dma_idle(input int quiet);
    int n;
    int idle;
    n    = 0;
    idle = 0;
    while (!timed_out && idle < quiet && n < WAIT_LIMIT) begin
      @(posedge S_AXI_ACLK);
      #1;
      n++;
      idle = m_axis_dma_tvalid ? 0 : idle + 1;
    end
    if (!timed_out && idle < quiet) begin
      note_timeout("DMA stream never went idle");
    end
  endtask

  // one gated burst, then a quiet window to catch surplus frames
  task automatic run_burst(input string name, input int frames, input int words,
                           input logic [31:0] strb);
    logic [31:0] gap;
    int          target;
    target = frame_count + frames;
    take_bits(gap_lfsr, 3, gap);
    @(posedge S_AXI_ACLK);
    #1;
    gen_cfg.gap       = gap;
    gen_cfg.frames    = frames;
    gen_cfg.words     = words;
    gen_cfg.last_strb = strb;
    gate              = 1'b1;
    @(posedge S_AXI_ACLK);
    #1;
    gate = 1'b0;
    wait_frames(target);
    repeat (30) @(posedge S_AXI_ACLK);
    #1;
    assert (frame_count == target) else begin
      $display("Error at %0t: frame_count expected %0d got %0d", $time, target, frame_count);
      tb_errors++;
    end
    finish_test(name);
  endtask

  initial begin
    S_AXI_ARESETN     = 1'b0;
    gate              = 1'b0;
    rst_count         = 1'b0;
    gen_cfg           = '0;
    stamp_counter     = '0;
    m_axis_tready     = 1'b0;
    m_axis_dma_tready = 1'b0;
    rdy_lfsr          = SEED;
    gap_lfsr          = SEED;
    repeat (3) @(posedge S_AXI_ACLK);
    #1;
    S_AXI_ARESETN = 1'b1;
    repeat (2) @(posedge S_AXI_ACLK);
    #1;
    finish_test("reset");
    run_burst("burst_short", 10, 3, 32'h0000_00ff);
    run_burst("burst_zero", 0, 2, 32'h0);
    run_burst("burst_single", 20, 1, 32'h0);
    run_burst("burst_long", 35, 6, 32'h0fff_ffff);
    // both drains must have finished by now
    wait_dma_idle(40);
    assert (pkt_count >= 2) else begin
      $display("Error at %0t: pkt_count expected >= 2 got %0d", $time, pkt_count);
      tb_errors++;
    end
    finish_test("drain");
    rst_count = 1'b1;
    @(posedge S_AXI_ACLK);
    #1;
    rst_count = 1'b0;
    run_burst("count_reset", 5, 2, 32'h0);
    $display("tests: %0d run, %0d failed, %0d errors", tests, failed, err_count + tb_errors);
    if (!timed_out && failed == 0 && err_count + tb_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== tx_stats.f ====
common/tx_stats_pkg.sv
tx_gen/tx_frame_gen.sv
rx_probe/rx_seq_probe.sv
stats/stat_fifo.sv
stats/stat_dma_drain.sv
verilog/tx_stats_top.sv
tb/tb_tx_stats_checks.sv
tb/tb_tx_stats.sv

// ==== Bender.yml ====
package:
  name: tx_stats

sources:
  - common/tx_stats_pkg.sv
  - tx_gen/tx_frame_gen.sv
  - rx_probe/rx_seq_probe.sv
  - stats/stat_fifo.sv
  - stats/stat_dma_drain.sv
  - verilog/tx_stats_top.sv
  - target: test
    files:
      - tb/tb_tx_stats_checks.sv
      - tb/tb_tx_stats.sv
